//--- tests/lut_map_cases.txt
// addr mult ofs, then pixels p0..p7, then expected e0..e7 (hex)
// table byte k = (k * mult + ofs) mod 256
00001000 01 00 00 01 7f 80 fe ff 10 a5 00 01 7f 80 fe ff 10 a5
00002000 ff ff 00 01 7f 80 fe ff 10 a5 ff fe 80 7f 01 00 ef 5a
0000a400 03 11 00 01 02 10 55 80 c3 ff 11 14 17 41 10 91 5a 0e
12345600 00 5a 00 ff 33 44 12 80 7e 01 5a 5a 5a 5a 5a 5a 5a 5a
0000c000 07 00 00 01 02 25 40 92 e0 ff 00 07 0e 03 c0 fe 20 f9
80000040 02 01 00 01 7f 80 81 c0 fe ff 01 03 ff 01 03 81 fd ff
0000f000 05 80 00 01 10 20 33 9a cc ff 80 85 d0 20 7f 82 7c 7b
00ff0010 01 80 00 01 7f 80 ff 3c c4 55 80 81 ff 00 7f bc 44 d5

//--- sources.f
+incdir+rtl
rtl/lut_mem_pkg.sv
rtl/lut_reg_pkg.sv
rtl/lut_reg_decode.sv
rtl/lut_fetch.sv
rtl/lut_fetch_fifo.sv
rtl/lut_map_execute.sv
rtl/lut_map_top.sv
tests/tb_lut_map.sv

//--- Makefile
SIM      = verilator
TOP      = tb_lut_map
FILELIST = sources.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_lut_map.sv
`default_nettype none
`timescale 1ns/1ps

`include "lut_consts.svh"

module tb_lut_map import lut_mem_pkg::*, lut_reg_pkg::*; ();

    localparam int NUM_CASES      = 8;
    localparam int CASE_WORDS     = 19;                       // addr, mult, ofs, 8 px, 8 exp
    localparam int BYTES_PER_BEAT = `MEM_BEAT_W / `LUT_BYTE_W;
    localparam int MAX_CYCLES     = NUM_CASES * 2000 + 500;

    logic        clk;
    logic        rst_n;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
    logic        rd_valid;
    mem_beat_t   rd_data;
    logic        rd_done;
    logic        px_valid;
    lut_byte_t   px_data;

    wire         awready;
    wire         wready;
    wire         bvalid;
    wire         arready;
    wire         rvalid;
    wire  [31:0] rdata;
    wire         rd_start;
    wire  [31:0] rd_addr;
    wire         y_valid;
    lut_byte_t   y_data;

    logic [31:0] case_mem [NUM_CASES * CASE_WORDS];
    int          beat_gap [`LUT_BEATS];
    int          cur_mult;
    int          cur_ofs;
    logic [31:0] exp_addr;
    int          req_count   = 0;
    int          cycle_count = 0;
    logic        px_valid_d  = 1'b0;
    lut_byte_t   exp_q [$];

    lut_map_top DUT (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
        .o_bvalid(bvalid), .i_bready(bready),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata),
        .o_rd_start(rd_start), .o_rd_addr(rd_addr),
        .i_rd_valid(rd_valid), .i_rd_data(rd_data), .i_rd_done(rd_done),
        .i_px_valid(px_valid), .i_px_data(px_data),
        .o_y_valid(y_valid), .o_y_data(y_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input lut_byte_t got, input lut_byte_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_stat(input string name, input stat_word_t got, input stat_word_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic stat_word_t stat_of(input logic busy, input logic loaded);
        stat_word_t st;
        st        = '0;
        st.busy   = busy;
        st.loaded = loaded;
        return st;
    endfunction

    // Table byte k of the current case
    function automatic lut_byte_t rule_byte(input int k);
        return lut_byte_t'((k * cur_mult + cur_ofs) % 256);
    endfunction

    function automatic mem_beat_t make_beat(input int beat);
        logic [`MEM_BEAT_W-1:0] bits;
        for (int j = 0; j < BYTES_PER_BEAT; j++)
            bits[j*8 +: 8] = rule_byte(beat * BYTES_PER_BEAT + j);   // Low byte, low index
        return mem_beat_t'(bits);
    endfunction

    // Entered and left 1 ns after a rising edge
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic done;
        done    = 1'b0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!done) begin
            @(negedge clk);
            done = awready && wready;
            @(posedge clk);
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = bvalid;                                    // bready is always high
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic done;
        done    = 1'b0;
        arvalid = 1'b1;
        araddr  = addr;
        while (!done) begin
            @(negedge clk);
            done = arready;
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rvalid;
            data = rdata;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_loaded();
        logic [31:0] word;
        stat_word_t  st;
        st = '0;
        while (!st.loaded) begin
            read_reg(`REG_STAT_OFS, word);
            st = stat_word_t'(word);
        end
        check_stat("o_rdata (status)", st, stat_of(1'b0, 1'b1));
    endtask

    // Memory model, sixteen beats per request with gaps picked by the stimulus
    initial begin : mem_model
        rd_valid = 1'b0;
        rd_data  = '0;
        rd_done  = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && rd_start) begin
                @(posedge clk);
                #1;
                for (int b = 0; b < `LUT_BEATS; b++) begin
                    repeat (beat_gap[b]) begin
                        @(posedge clk);
                        #1;
                    end
                    rd_valid = 1'b1;
                    rd_data  = make_beat(b);
                    rd_done  = (b == `LUT_BEATS - 1);
                    @(posedge clk);
                    #1;
                    rd_valid = 1'b0;
                    rd_done  = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && rd_start) begin
            req_count = req_count + 1;
            check_word("o_rd_addr", rd_addr, exp_addr);
        end
    end

    // Result one cycle after each pixel
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("o_y_valid", y_valid, px_valid_d);
            if (px_valid_d) begin
                if (exp_q.size() == 0)
                    abort_run("Lookup result arrived with no pixel waiting for it");
                else
                    check_byte("o_y_data", y_data, exp_q.pop_front());
            end
            px_valid_d = px_valid;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
    end

    initial begin : stimulus
        int          base;
        int          reqs;
        int          gap;
        logic [31:0] word;
        lut_byte_t   px;
        lut_byte_t   ex;

        void'($urandom(32'hb4f));
        rst_n    = 1'b0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        bready   = 1'b1;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b1;
        px_valid = 1'b0;
        px_data  = '0;
        exp_addr = '0;
        cur_mult = 0;
        cur_ofs  = 0;
        foreach (beat_gap[b])
            beat_gap[b] = 0;
        foreach (case_mem[i])
            case_mem[i] = 32'hffff_ffff;                      // Marks words the file left empty
        $readmemh("tests/lut_map_cases.txt", case_mem);
        if (case_mem[NUM_CASES * CASE_WORDS - 1] === 32'hffff_ffff)
            abort_run("Case file is missing or holds too few cases");

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_reg(`REG_STAT_OFS, word);
        check_stat("o_rdata (status)", stat_word_t'(word), stat_of(1'b0, 1'b0));

        for (int c = 0; c < NUM_CASES; c++) begin
            base     = c * CASE_WORDS;
            exp_addr = case_mem[base];
            cur_mult = int'(case_mem[base + 1][7:0]);
            cur_ofs  = int'(case_mem[base + 2][7:0]);

            write_reg(`REG_ADDR_OFS, exp_addr);
            read_reg(`REG_ADDR_OFS, word);
            check_word("o_rdata (address)", word, exp_addr);

            foreach (beat_gap[b])
                beat_gap[b] = $urandom % 4;
            reqs = req_count;
            write_reg(`REG_CTRL_OFS, 32'h1);
            read_reg(`REG_STAT_OFS, word);
            check_stat("o_rdata (status)", stat_word_t'(word), stat_of(1'b1, 1'b0));
            write_reg(`REG_CTRL_OFS, 32'h1);                  // Lands while busy
            wait_loaded();
            if (req_count != reqs + 1)
                abort_run($sformatf("Case %0d issued %0d read requests instead of one",
                                    c, req_count - reqs));

            for (int p = 0; p < 8; p++) begin
                px = case_mem[base + 3 + p][7:0];
                ex = case_mem[base + 11 + p][7:0];
                if (ex !== rule_byte(int'(px)))
                    abort_run($sformatf("Case %0d pixel %0d: file value disagrees with rule", c, p));
                exp_q.push_back(ex);
                px_valid = 1'b1;
                px_data  = px;
                @(posedge clk);
                #1;
                px_valid = 1'b0;
                gap = $urandom % 2;                           // Often back to back
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            repeat (2) begin
                @(posedge clk);
                #1;
            end
            if (exp_q.size() != 0)
                abort_run($sformatf("Case %0d: %0d lookup results never came", c, exp_q.size()));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/lut_map_top.sv
`default_nettype none
`timescale 1ns/1ps

module lut_map_top import lut_mem_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    input  wire            i_awvalid,
    output logic           o_awready,
    input  wire  [31:0]    i_awaddr,
    input  wire            i_wvalid,
    output logic           o_wready,
    input  wire  [31:0]    i_wdata,
    output logic           o_bvalid,
    input  wire            i_bready,
    input  wire            i_arvalid,
    output logic           o_arready,
    input  wire  [31:0]    i_araddr,
    output logic           o_rvalid,
    input  wire            i_rready,
    output logic [31:0]    o_rdata,

    output logic           o_rd_start,
    output logic [31:0]    o_rd_addr,
    input  wire            i_rd_valid,
    input  wire mem_beat_t i_rd_data,
    input  wire            i_rd_done,

    input  wire            i_px_valid,
    input  wire lut_byte_t i_px_data,
    output logic           o_y_valid,
    output lut_byte_t      o_y_data
);

    logic        start;
    logic [31:0] fetch_addr;
    logic        fetch_busy;
    logic        beat_we;
    logic        ram_we;
    lut_idx_t    ram_idx;
    lut_byte_t   ram_data;
    logic        fifo_done;
    logic        loading;
    logic        loaded;

    // Status source, load ends when fetch is idle and the FIFO drained
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            loading <= 1'b0;
            loaded  <= 1'b0;
        end else if (start) begin
            loading <= 1'b1;
            loaded  <= 1'b0;
        end else if (loading && !fetch_busy && fifo_done) begin
            loading <= 1'b0;
            loaded  <= 1'b1;
        end
    end

    lut_reg_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
        .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
        .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata),
        .o_start(start), .o_fetch_addr(fetch_addr),
        .i_busy(loading), .i_loaded(loaded)
    );

    lut_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .i_start(start), .i_fetch_addr(fetch_addr),
        .o_rd_start(o_rd_start), .o_rd_addr(o_rd_addr),
        .i_rd_valid(i_rd_valid), .i_rd_done(i_rd_done),
        .o_beat_we(beat_we), .o_busy(fetch_busy)
    );

    lut_fetch_fifo u_fifo (
        .clk(clk), .rst_n(rst_n),
        .i_beat(i_rd_data), .i_beat_we(beat_we),
        .o_ram_we(ram_we), .o_ram_idx(ram_idx), .o_ram_data(ram_data),
        .o_done(fifo_done)
    );

    lut_map_execute u_execute (
        .clk(clk), .rst_n(rst_n),
        .i_ram_we(ram_we), .i_ram_idx(ram_idx), .i_ram_data(ram_data),
        .i_px_valid(i_px_valid), .i_px_data(i_px_data),
        .o_y_valid(o_y_valid), .o_y_data(o_y_data)
    );

endmodule

`default_nettype wire

//--- rtl/lut_map_execute.sv
`default_nettype none
`timescale 1ns/1ps

`include "lut_consts.svh"

module lut_map_execute import lut_mem_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    // Table load port from the FIFO
    input  wire            i_ram_we,
    input  wire lut_idx_t  i_ram_idx,
    input  wire lut_byte_t i_ram_data,

    // Pixel stream
    input  wire            i_px_valid,
    input  wire lut_byte_t i_px_data,
    output logic           o_y_valid,
    output lut_byte_t      o_y_data
);

    lut_byte_t table_ram [`LUT_LEN];
    lut_idx_t  px_idx;

    // Pixel value is the table index
    assign px_idx = lut_idx_t'(i_px_data);

    always_ff @(posedge clk) begin
        if (i_ram_we)
            table_ram[i_ram_idx] <= i_ram_data;
    end

    // Registered read, this is the result stage
    always_ff @(posedge clk) begin
        if (i_px_valid)
            o_y_data <= table_ram[px_idx];
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            o_y_valid <= 1'b0;
        else
            o_y_valid <= i_px_valid;                  // Matches the one-cycle read
    end

endmodule

`default_nettype wire

//--- rtl/lut_fetch_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "lut_consts.svh"

module lut_fetch_fifo import lut_mem_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    input  wire mem_beat_t i_beat,
    input  wire            i_beat_we,

    output logic           o_ram_we,
    output lut_idx_t       o_ram_idx,
    output lut_byte_t      o_ram_data,
    output logic           o_done
);

    localparam int PTR_W          = $clog2(`LUT_BEATS);
    localparam int BYTES_PER_BEAT = `MEM_BEAT_W / `LUT_BYTE_W;
    localparam int SEL_W          = $clog2(BYTES_PER_BEAT);

    mem_beat_t              beat_mem [`LUT_BEATS];
    logic [PTR_W:0]         wr_ptr;                   // Extra bit tells full from empty
    logic [PTR_W:0]         rd_ptr;
    logic [SEL_W-1:0]       byte_sel;                 // Byte within the head beat
    lut_idx_t               ram_idx;
    logic [`MEM_BEAT_W-1:0] head;
    logic                   empty;
    logic                   full;
    logic                   last_byte;

    assign empty     = wr_ptr == rd_ptr;
    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head      = beat_mem[rd_ptr[PTR_W-1:0]];
    assign last_byte = byte_sel == SEL_W'(BYTES_PER_BEAT - 1);

    // Drain one byte per cycle, low bytes first
    assign o_ram_we   = !empty;
    assign o_ram_idx  = ram_idx;
    assign o_ram_data = head[byte_sel * `LUT_BYTE_W +: `LUT_BYTE_W];
    assign o_done     = empty && byte_sel == '0;

    always_ff @(posedge clk) begin
        if (i_beat_we)
            beat_mem[wr_ptr[PTR_W-1:0]] <= i_beat;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            byte_sel <= '0;
            ram_idx  <= '0;
        end else begin
            if (i_beat_we)
                wr_ptr <= wr_ptr + 1'b1;

            if (!empty) begin
                byte_sel <= byte_sel + 1'b1;          // Wraps to 0 after the last byte
                if (last_byte)
                    rd_ptr <= rd_ptr + 1'b1;
            end

            // New table starts at entry 0
            if (o_done && i_beat_we)
                ram_idx <= '0;
            else if (!empty)
                ram_idx <= ram_idx + 1'b1;
        end
    end

    // Depth equals one full table, so a burst never overruns
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) i_beat_we |-> !full
    ) else $error("beat FIFO overflow");

endmodule

`default_nettype wire

//--- rtl/lut_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module lut_fetch (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         i_start,
    input  wire  [31:0] i_fetch_addr,

    output logic        o_rd_start,
    output logic [31:0] o_rd_addr,
    input  wire         i_rd_valid,
    input  wire         i_rd_done,

    output logic        o_beat_we,
    output logic        o_busy
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_ADDR,
        RECV_DATA
    } state_t;

    state_t state;
    state_t nxt_state;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    // Base address held for the whole burst
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            o_rd_addr <= '0;
        else if (state == IDLE && i_start)
            o_rd_addr <= i_fetch_addr;
    end

    always_comb begin
        nxt_state  = state;
        o_rd_start = 1'b0;
        o_beat_we  = 1'b0;

        case (state)
            IDLE: begin
                if (i_start)
                    nxt_state = SEND_ADDR;
            end
            SEND_ADDR: begin
                o_rd_start = 1'b1;                    // Single request cycle
                nxt_state  = RECV_DATA;
            end
            default: begin
                o_beat_we = i_rd_valid;               // No back-pressure on beats
                if (i_rd_done)
                    nxt_state = IDLE;
            end
        endcase
    end

    assign o_busy = state != IDLE;

endmodule

`default_nettype wire

//--- rtl/lut_reg_decode.sv
`default_nettype none
`timescale 1ns/1ps

`include "lut_consts.svh"

module lut_reg_decode import lut_reg_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         i_awvalid,
    output logic        o_awready,
    input  wire  [31:0] i_awaddr,
    input  wire         i_wvalid,
    output logic        o_wready,
    input  wire  [31:0] i_wdata,
    output logic        o_bvalid,
    input  wire         i_bready,

    input  wire         i_arvalid,
    output logic        o_arready,
    input  wire  [31:0] i_araddr,
    output logic        o_rvalid,
    input  wire         i_rready,
    output logic [31:0] o_rdata,

    output logic        o_start,
    output logic [31:0] o_fetch_addr,
    input  wire         i_busy,
    input  wire         i_loaded
);

    logic        wr_acc;
    logic        rd_acc;
    reg_word_u   wr_word;
    logic [31:0] addr_q;
    stat_word_t  stat;

    // Address and data must arrive together, one write in flight
    assign wr_acc    = i_awvalid && i_wvalid && !o_bvalid;
    assign rd_acc    = i_arvalid && !o_rvalid;
    assign o_awready = wr_acc;
    assign o_wready  = wr_acc;
    assign o_arready = rd_acc;

    assign wr_word      = i_wdata;
    assign o_fetch_addr = addr_q;

    always_comb begin
        stat        = '0;
        stat.busy   = i_busy;
        stat.loaded = i_loaded;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            o_bvalid <= 1'b0;
            o_start  <= 1'b0;
            addr_q   <= '0;
        end else begin
            if (wr_acc)
                o_bvalid <= 1'b1;
            else if (i_bready)
                o_bvalid <= 1'b0;

            if (wr_acc && i_awaddr == `REG_ADDR_OFS)
                addr_q <= wr_word.addr;

            // One-cycle pulse, dropped while a load runs
            o_start <= wr_acc && i_awaddr == `REG_CTRL_OFS && wr_word.ctrl.start && !i_busy;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            o_rvalid <= 1'b0;
        else if (rd_acc)
            o_rvalid <= 1'b1;
        else if (i_rready)
            o_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            case (i_araddr)
                `REG_ADDR_OFS: o_rdata <= addr_q;
                `REG_STAT_OFS: o_rdata <= stat;
                default:       o_rdata <= '0;       // CTRL reads back zero
            endcase
        end
    end

    // Start lasts one cycle because the open write response blocks the next handshake
    a_start_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) o_start |=> !o_start
    ) else $error("start held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/lut_reg_pkg.sv
`default_nettype none

package lut_reg_pkg;

    // Control register at the CTRL offset
    typedef struct packed {
        logic [30:0] rsvd;                            // Ignored on write
        logic        start;                           // Self-clearing
    } ctrl_word_t;

    // Status register at the STAT offset
    typedef struct packed {
        logic [29:0] rsvd;                            // Read as zero
        logic        loaded;                          // Table valid
        logic        busy;                            // Load in progress
    } stat_word_t;

    // Write data word, meaning depends on the register offset
    typedef union packed {
        logic [31:0] addr;                            // Table base in memory
        ctrl_word_t  ctrl;
    } reg_word_u;

endpackage

`default_nettype wire

//--- rtl/lut_mem_pkg.sv
`default_nettype none

`include "lut_consts.svh"

package lut_mem_pkg;

    // 32-bit words in one memory beat
    localparam int BEAT_WORDS = `MEM_BEAT_W / 32;

    // One table entry, also one pixel
    typedef logic [`LUT_BYTE_W-1:0] lut_byte_t;

    // Table index
    typedef logic [$clog2(`LUT_LEN)-1:0] lut_idx_t;

    // One memory beat, word 0 holds the lowest bytes
    typedef logic [BEAT_WORDS-1:0][31:0] mem_beat_t;

endpackage

`default_nettype wire

//--- rtl/lut_consts.svh
`ifndef LUT_CONSTS_SVH
`define LUT_CONSTS_SVH

// Table geometry
`define LUT_BYTE_W 8                                  // Bits per table entry
`define LUT_LEN 256                                   // Entries per table

// Memory side
`define MEM_BEAT_W 128                                // Bits per read beat

// Beats needed to fill one table
`define LUT_BEATS ((`LUT_LEN * `LUT_BYTE_W) / `MEM_BEAT_W)

// Register map, byte offsets on the AXI4-Lite bus
`define REG_ADDR_OFS 32'h0                            // Table base address
`define REG_CTRL_OFS 32'h4                            // Control, start in bit 0
`define REG_STAT_OFS 32'h8                            // Status, busy and loaded

`endif
